// ==== run.sh ====
#!/bin/sh
# Build and run the execute stage testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f tb.f --top-module exec_tb -o exec_sim &&
./obj_dir/exec_sim > sim.log 2>&1 &&
! grep -q "CHECKS FAILED" sim.log &&
tail -n 2 sim.log &&
echo "run.sh: simulation passed" ||
{ tail -n 20 sim.log 2>/dev/null; echo "run.sh: build or simulation failed"; exit 1; }

// ==== source/exec_alu.sv ====
module exec_alu (
    input  logic                         clk,
    input  logic                         reset,
    input  exec_pkg::ctl_t               ctl_i,
    input  logic [exec_pkg::XLEN-1:0]    rdata_a_i,
    input  logic [exec_pkg::XLEN-1:0]    rdata_b_i,
    input  logic                         flags_we_i,
    output logic [exec_pkg::XLEN-1:0]    result_o,
    output logic                         cond_true_o
);
    import exec_pkg::*;

    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] add_b;     // Second adder input, inverted to subtract
    logic            add_cin;
    logic [XLEN:0]   sum;
    logic [3:0]      nzcv_q;    // N Z C V from the top bit down
    logic            n_d;
    logic            z_d;
    logic            c_d;
    logic            v_d;
    logic [15:0]     cond_q;
    logic [15:0]     cond_d;

    assign op_b = ctl_i.use_imm ? {{(XLEN-IMM_W){1'b0}}, ctl_i.imm} : rdata_b_i;

    always_comb begin
        add_b   = op_b;
        add_cin = 1'b0;
        case (ctl_i.op)
            ALU_SUB: begin
                add_b   = ~op_b;
                add_cin = 1'b1;
            end
            ALU_ADC: add_cin = nzcv_q[1];
            ALU_SBC: begin
                // Carry set means no borrow
                add_b   = ~op_b;
                add_cin = nzcv_q[1];
            end
            default: ;
        endcase
    end

    assign sum = {1'b0, rdata_a_i} + {1'b0, add_b} + {{XLEN{1'b0}}, add_cin};

    always_comb begin
        c_d = nzcv_q[1];    // Logic ops keep C and V
        v_d = nzcv_q[0];
        case (ctl_i.op)
            ALU_MOV: result_o = op_b;
            ALU_AND: result_o = rdata_a_i & op_b;
            ALU_OR:  result_o = rdata_a_i | op_b;
            ALU_XOR: result_o = rdata_a_i ^ op_b;
            default: begin
                result_o = sum[XLEN-1:0];
                c_d      = sum[XLEN];
                v_d      = (rdata_a_i[XLEN-1] == add_b[XLEN-1])
                         && (sum[XLEN-1] != rdata_a_i[XLEN-1]);
            end
        endcase
        n_d = result_o[XLEN-1];
        z_d = (result_o == '0);
    end

    always_comb begin
        cond_d             = '0;
        cond_d[COND_AL]    = 1'b1;
        cond_d[COND_EQ]    = z_d;
        cond_d[COND_NE]    = !z_d;
        cond_d[COND_CS]    = c_d;
        cond_d[COND_NC]    = !c_d;
        cond_d[COND_SS]    = n_d;
        cond_d[COND_NS]    = !n_d;
        cond_d[COND_OV]    = v_d;
        cond_d[COND_NV]    = !v_d;
        cond_d[COND_AB]    = c_d || !z_d;
        cond_d[COND_BE]    = !c_d || z_d;
        cond_d[COND_GE]    = !(n_d ^ v_d);
        cond_d[COND_LT]    = n_d ^ v_d;
        cond_d[COND_GT]    = !z_d && !(n_d ^ v_d);
        cond_d[COND_LE]    = z_d || (n_d ^ v_d);
        cond_d[COND_AL_HI] = 1'b1;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            nzcv_q <= 4'b0000;
            cond_q <= FLAGS_RESET;
        end else if (flags_we_i) begin
            nzcv_q <= {n_d, z_d, c_d, v_d};
            cond_q <= cond_d;
        end
    end

    assign cond_true_o = cond_q[ctl_i.cond];

endmodule

// ==== source/exec_fsm.sv ====
module exec_fsm (
    input  logic              clk,
    input  logic              reset,
    input  logic              req_i,
    output logic              rdy_o,
    input  exec_pkg::ctl_t    ctl_i,
    output exec_pkg::ctl_t    ctl_o,
    output exec_pkg::state_t  state_o,
    input  logic              cond_true_i,
    input  logic              mem_done_i,
    output logic              rf_we_o,
    output logic              wb_sel_mem_o,
    output logic              mar_load_o,
    output logic              dtw_load_o,
    output logic              mem_go_o,
    output logic              pc_step_o,
    output logic              pc_branch_o,
    output logic              pc_jump_o,
    output logic              flags_we_o,
    output logic              flush_o
);
    import exec_pkg::*;

    state_t state_q;
    state_t state_d;
    ctl_t   ctl_q;      // Instruction held after accept
    logic   in_exec;
    logic   rd_is_pc;
    logic   is_load;
    logic   is_store;
    logic   to_reg;

    assign rdy_o     = (state_q == IDLE);
    assign state_o   = state_q;
    assign in_exec   = (state_q == EXEC);
    assign rd_is_pc  = (ctl_q.rd == REG_PC);
    assign is_load   = (ctl_q.dst == DST_LOAD);
    assign is_store  = (ctl_q.dst == DST_STORE);
    assign to_reg    = (ctl_q.dst == DST_REG);

    // Decode straight from the input while idle, so branch conditions resolve at accept
    always_comb begin
        ctl_o = rdy_o ? ctl_i : ctl_q;
        if (in_exec && is_store) begin
            // Pass rd through the ALU as store data
            ctl_o.op      = ALU_MOV;
            ctl_o.use_imm = 1'b0;
            ctl_o.rn      = ctl_q.rd;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (req_i) begin
                    if (!ctl_i.is_branch) begin
                        state_d = EXEC;
                    end else if (cond_true_i) begin
                        state_d = BRANCH;
                    end
                end
            end
            EXEC: begin
                case (ctl_q.dst)
                    DST_LOAD:  state_d = MEM_RD;
                    DST_STORE: state_d = ADDR;
                    default:   state_d = IDLE;
                endcase
            end
            ADDR:   state_d = MEM_WR;
            MEM_RD: begin
                if (mem_done_i) begin
                    state_d = WB;
                end
            end
            MEM_WR: begin
                if (mem_done_i) begin
                    state_d = IDLE;
                end
            end
            WB:      state_d = rd_is_pc ? BRANCH : IDLE;   // Loaded PC goes out as a jump
            default: state_d = IDLE;
        endcase
    end

    // Steering
    assign pc_step_o    = rdy_o && req_i;
    assign rf_we_o      = !rd_is_pc && ((in_exec && to_reg) || state_q == WB);
    assign wb_sel_mem_o = (state_q == WB) || (state_q == BRANCH);
    assign mar_load_o   = (in_exec && is_load) || (state_q == ADDR);
    assign mem_go_o     = mar_load_o;   // Strobe starts as the address lands
    assign dtw_load_o   = in_exec && is_store;
    assign flags_we_o   = in_exec && ctl_q.set_flags;
    assign pc_branch_o  = (state_q == BRANCH) && ctl_q.is_branch;
    assign pc_jump_o    = (in_exec && to_reg && rd_is_pc)
                        || ((state_q == BRANCH) && !ctl_q.is_branch);

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= IDLE;
            flush_o <= 1'b0;
        end else begin
            state_q <= state_d;
            flush_o <= pc_branch_o || pc_jump_o;
        end
    end

    always_ff @(posedge clk) begin
        if (pc_step_o) begin
            ctl_q <= ctl_i;
        end
    end

    // Every PC redirect returns through IDLE before the next one
    assert property (@(posedge clk) disable iff (reset) flush_o |=> !flush_o);

endmodule

// ==== source/exec_mem_port.sv ====
module exec_mem_port (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         dtw_load_i,
    input  logic                         mar_load_i,
    input  logic                         go_i,
    input  logic                         we_i,
    input  logic [exec_pkg::XLEN-1:0]    data_i,
    output exec_pkg::mem_req_t           mem_o,
    output logic                         mem_stb_o,
    input  logic [exec_pkg::XLEN-1:0]    mem_rdata_i,
    input  logic                         mem_ack_i,
    input  logic                         mem_stall_i,
    output logic [exec_pkg::XLEN-1:0]    rdata_o,
    output logic                         done_o
);
    import exec_pkg::*;

    logic [XLEN-1:0] mar_q;
    logic [XLEN-1:0] dtw_q;
    logic [XLEN-1:0] rdata_q;
    logic            we_q;
    logic            stb_q;
    logic            busy_q;    // Between first strobe and acknowledge

    assign mem_o     = '{addr: mar_q, wdata: dtw_q, we: we_q};
    assign mem_stb_o = stb_q;
    assign done_o    = busy_q && mem_ack_i;
    assign rdata_o   = rdata_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            stb_q  <= 1'b0;
            busy_q <= 1'b0;
            we_q   <= 1'b0;
        end else if (go_i) begin
            stb_q  <= 1'b1;
            busy_q <= 1'b1;
            we_q   <= we_i;
        end else if (busy_q) begin
            if (!mem_stall_i || mem_ack_i) begin
                stb_q <= 1'b0;      // Memory took the request
            end
            if (mem_ack_i) begin
                busy_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mar_load_i) begin
            mar_q <= data_i;
        end
        if (dtw_load_i) begin
            dtw_q <= data_i;
        end
        if (done_o) begin
            rdata_q <= mem_rdata_i;
        end
    end

    // Address and data held until the acknowledge
    assert property (@(posedge clk) disable iff (reset)
        busy_q && !mem_ack_i |=> $stable(mem_o));

endmodule

// ==== source/exec_pc.sv ====
module exec_pc (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         step_i,
    input  logic                         branch_i,
    input  logic                         jump_i,
    input  logic [exec_pkg::IMM_W-1:0]   imm_i,
    input  logic [exec_pkg::XLEN-1:0]    target_i,
    output logic [exec_pkg::XLEN-1:0]    pc_o,
    output logic [exec_pkg::XLEN-1:0]    newpc_o
);
    import exec_pkg::*;

    logic [XLEN-1:0] imm_sext;
    logic [XLEN-1:0] branch_target;

    assign imm_sext = {{(XLEN-IMM_W){imm_i[IMM_W-1]}}, imm_i};

    // PC already points past the branch
    assign branch_target = pc_o - PC_STEP + imm_sext;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc_o    <= '0;
            newpc_o <= '0;
        end else if (step_i) begin
            pc_o <= pc_o + PC_STEP;
        end else if (branch_i) begin
            pc_o    <= branch_target;
            newpc_o <= branch_target;
        end else if (jump_i) begin
            pc_o    <= target_i;
            newpc_o <= target_i;   // Write to r15
        end
    end

endmodule

// ==== source/exec_pkg.sv ====
package exec_pkg;

    localparam int XLEN  = 32;
    localparam int REG_W = 4;
    localparam int IMM_W = 16;

    localparam logic [REG_W-1:0] REG_PC      = 4'd15;   // Index that reads and jumps the PC
    localparam logic [XLEN-1:0]  PC_STEP     = 32'd4;
    localparam logic [15:0]      FLAGS_RESET = 16'h8001;

    // Positions in the branch condition vector
    localparam logic [3:0] COND_AL    = 4'd0;
    localparam logic [3:0] COND_EQ    = 4'd1;
    localparam logic [3:0] COND_NE    = 4'd2;
    localparam logic [3:0] COND_CS    = 4'd3;
    localparam logic [3:0] COND_NC    = 4'd4;
    localparam logic [3:0] COND_SS    = 4'd5;
    localparam logic [3:0] COND_NS    = 4'd6;
    localparam logic [3:0] COND_OV    = 4'd7;
    localparam logic [3:0] COND_NV    = 4'd8;
    localparam logic [3:0] COND_AB    = 4'd9;
    localparam logic [3:0] COND_BE    = 4'd10;
    localparam logic [3:0] COND_GE    = 4'd11;
    localparam logic [3:0] COND_LT    = 4'd12;
    localparam logic [3:0] COND_GT    = 4'd13;
    localparam logic [3:0] COND_LE    = 4'd14;
    localparam logic [3:0] COND_AL_HI = 4'd15;

    typedef enum logic [3:0] {
        ALU_MOV,
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_ADC,
        ALU_SBC
    } alu_op_t;

    typedef enum logic [1:0] {
        DST_NONE,
        DST_REG,    // ALU result to rd
        DST_LOAD,   // Memory word to rd
        DST_STORE   // rd to memory
    } dst_t;

    // Decoded instruction as handed over by decode
    typedef struct packed {
        alu_op_t          op;
        logic [IMM_W-1:0] imm;
        logic [REG_W-1:0] rd;
        logic [REG_W-1:0] rm;
        logic [REG_W-1:0] rn;
        logic             use_imm;    // Second operand is zero-extended imm
        dst_t             dst;
        logic             set_flags;
        logic             is_branch;
        logic [3:0]       cond;
    } ctl_t;

    typedef struct packed {
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
        logic            we;
    } mem_req_t;

    typedef enum logic [2:0] {
        IDLE,
        EXEC,
        ADDR,
        MEM_RD,
        MEM_WR,
        WB,
        BRANCH
    } state_t;

endpackage

// ==== source/exec_regfile.sv ====
module exec_regfile (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         we_i,
    input  logic [exec_pkg::REG_W-1:0]   waddr_i,
    input  logic [exec_pkg::XLEN-1:0]    wdata_i,
    input  logic [exec_pkg::REG_W-1:0]   raddr_a_i,
    input  logic [exec_pkg::REG_W-1:0]   raddr_b_i,
    input  logic [exec_pkg::XLEN-1:0]    pc_i,
    output logic [exec_pkg::XLEN-1:0]    rdata_a_o,
    output logic [exec_pkg::XLEN-1:0]    rdata_b_o
);
    import exec_pkg::*;

    logic [XLEN-1:0] regs [REG_PC];   // r0 to r14
    logic            wr_en;

    assign wr_en = we_i && (waddr_i != REG_PC);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < REG_PC; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // r15 is the live program counter
    assign rdata_a_o = (raddr_a_i == REG_PC) ? pc_i : regs[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == REG_PC) ? pc_i : regs[raddr_b_i];

    // Writes to r15 must have been turned into jumps upstream
    assert property (@(posedge clk) disable iff (reset) we_i |-> waddr_i != REG_PC);

endmodule

// ==== source/exec_top.sv ====
module exec_top (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         req_i,
    output logic                         rdy_o,
    input  exec_pkg::ctl_t               ctl_i,
    output exec_pkg::mem_req_t           mem_o,
    output logic                         mem_stb_o,
    input  logic [exec_pkg::XLEN-1:0]    mem_rdata_i,
    input  logic                         mem_ack_i,
    input  logic                         mem_stall_i,
    output logic [exec_pkg::XLEN-1:0]    newpc_o,
    output logic                         flush_o
);
    import exec_pkg::*;

    ctl_t            ctl;
    state_t          state;
    logic            cond_true;
    logic            mem_done;
    logic            rf_we;
    logic            wb_sel_mem;
    logic            mar_load;
    logic            dtw_load;
    logic            mem_go;
    logic            pc_step;
    logic            pc_branch;
    logic            pc_jump;
    logic            flags_we;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] rdata_a;
    logic [XLEN-1:0] rdata_b;
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] mem_rdata;
    logic [XLEN-1:0] wb_data;

    // Writeback and jump target share one bus
    assign wb_data = wb_sel_mem ? mem_rdata : alu_result;

    exec_fsm exec_fsm_i (
        .clk          (clk),
        .reset        (reset),
        .req_i        (req_i),
        .rdy_o        (rdy_o),
        .ctl_i        (ctl_i),
        .ctl_o        (ctl),
        .state_o      (state),
        .cond_true_i  (cond_true),
        .mem_done_i   (mem_done),
        .rf_we_o      (rf_we),
        .wb_sel_mem_o (wb_sel_mem),
        .mar_load_o   (mar_load),
        .dtw_load_o   (dtw_load),
        .mem_go_o     (mem_go),
        .pc_step_o    (pc_step),
        .pc_branch_o  (pc_branch),
        .pc_jump_o    (pc_jump),
        .flags_we_o   (flags_we),
        .flush_o      (flush_o)
    );

    exec_pc exec_pc_i (
        .clk      (clk),
        .reset    (reset),
        .step_i   (pc_step),
        .branch_i (pc_branch),
        .jump_i   (pc_jump),
        .imm_i    (ctl.imm),
        .target_i (wb_data),
        .pc_o     (pc),
        .newpc_o  (newpc_o)
    );

    exec_regfile exec_regfile_i (
        .clk       (clk),
        .reset     (reset),
        .we_i      (rf_we),
        .waddr_i   (ctl.rd),
        .wdata_i   (wb_data),
        .raddr_a_i (ctl.rm),
        .raddr_b_i (ctl.rn),
        .pc_i      (pc),
        .rdata_a_o (rdata_a),
        .rdata_b_o (rdata_b)
    );

    exec_alu exec_alu_i (
        .clk         (clk),
        .reset       (reset),
        .ctl_i       (ctl),
        .rdata_a_i   (rdata_a),
        .rdata_b_i   (rdata_b),
        .flags_we_i  (flags_we),
        .result_o    (alu_result),
        .cond_true_o (cond_true)
    );

    exec_mem_port exec_mem_port_i (
        .clk         (clk),
        .reset       (reset),
        .dtw_load_i  (dtw_load),
        .mar_load_i  (mar_load),
        .go_i        (mem_go),
        .we_i        (state == ADDR),   // Only stores start from ADDR
        .data_i      (alu_result),
        .mem_o       (mem_o),
        .mem_stb_o   (mem_stb_o),
        .mem_rdata_i (mem_rdata_i),
        .mem_ack_i   (mem_ack_i),
        .mem_stall_i (mem_stall_i),
        .rdata_o     (mem_rdata),
        .done_o      (mem_done)
    );

endmodule

// ==== tb.f ====
source/exec_pkg.sv
source/exec_fsm.sv
source/exec_pc.sv
source/exec_regfile.sv
source/exec_alu.sv
source/exec_mem_port.sv
source/exec_top.sv
tb/exec_tb.sv

// ==== tb/exec_tb.sv ====
module exec_tb;
    import exec_pkg::*;

    localparam int          RESET_CYCLES = 16;
    localparam int          WAIT_LIMIT   = 64;   // Cycles any single wait may take
    localparam logic [31:0] SEED         = 32'd91493;

    logic            clk;
    logic            reset;
    logic            req_i;
    logic            rdy_o;
    ctl_t            ctl_i;
    mem_req_t        mem_o;
    logic            mem_stb_o;
    logic [XLEN-1:0] mem_rdata_i;
    logic            mem_ack_i;
    logic            mem_stall_i;
    logic [XLEN-1:0] newpc_o;
    logic            flush_o;

    // Reference model of the architectural state
    logic [XLEN-1:0] exp_regs [15];
    logic [XLEN-1:0] exp_pc;        // Address of the next instruction
    logic [XLEN-1:0] exp_addr;
    logic [XLEN-1:0] exp_wdata;
    logic            exp_we;
    logic [XLEN-1:0] exp_newpc;
    logic            flush_allowed;
    logic            taken_expected;

    logic [31:0]     stim_lfsr;
    logic [31:0]     mem_lfsr;
    logic [XLEN-1:0] mem_words [256];
    int              mem_phase = 0;   // 0 idle, 1 stalling, 2 counting down to ack
    int              mem_delay = 0;
    int              stall_run = 0;

    int              value_errors = 0;
    int              timeouts = 0;
    int              accepted = 0;

    logic            reg_accept;
    logic            skip_accept;

    exec_top exec_top_i (
        .clk         (clk),
        .reset       (reset),
        .req_i       (req_i),
        .rdy_o       (rdy_o),
        .ctl_i       (ctl_i),
        .mem_o       (mem_o),
        .mem_stb_o   (mem_stb_o),
        .mem_rdata_i (mem_rdata_i),
        .mem_ack_i   (mem_ack_i),
        .mem_stall_i (mem_stall_i),
        .newpc_o     (newpc_o),
        .flush_o     (flush_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    assign reg_accept  = rdy_o && req_i && !ctl_i.is_branch && ctl_i.dst == DST_REG;
    assign skip_accept = rdy_o && req_i && ctl_i.is_branch && !taken_expected;

    after_reset: assert property (@(posedge clk)
        $fell(reset) |-> rdy_o && !mem_stb_o && !flush_o && newpc_o == '0)
        else begin
            value_errors++;
            $display("Fail %0t: outputs not at their reset values", $time);
        end

    mem_request: assert property (@(posedge clk) disable iff (reset)
        mem_stb_o |-> mem_o.addr == exp_addr && mem_o.we == exp_we
                      && (!exp_we || mem_o.wdata == exp_wdata))
        else begin
            value_errors++;
            $display("Fail %0t: memory request addr %h we %b wdata %h, expected %h %b %h",
                     $time, mem_o.addr, mem_o.we, mem_o.wdata, exp_addr, exp_we, exp_wdata);
        end

    stall_hold: assert property (@(posedge clk) disable iff (reset)
        mem_stb_o && mem_stall_i |=> $stable(mem_o))
        else begin
            value_errors++;
            $display("Fail %0t: memory request changed during a stall", $time);
        end

    flush_target: assert property (@(posedge clk) disable iff (reset)
        flush_o |-> flush_allowed && newpc_o == exp_newpc)
        else begin
            value_errors++;
            $display("Fail %0t: flush with newpc %h, expected %h (flush expected %b)",
                     $time, newpc_o, exp_newpc, flush_allowed);
        end

    alu_busy: assert property (@(posedge clk) disable iff (reset) reg_accept |=> !rdy_o)
        else begin
            value_errors++;
            $display("Fail %0t: rdy_o still high after an ALU accept", $time);
        end

    alu_done: assert property (@(posedge clk) disable iff (reset) $past(reg_accept, 2) |-> rdy_o)
        else begin
            value_errors++;
            $display("Fail %0t: rdy_o low two edges after an ALU accept", $time);
        end

    branch_skip: assert property (@(posedge clk) disable iff (reset) skip_accept |=> rdy_o)
        else begin
            value_errors++;
            $display("Fail %0t: rdy_o dropped on a branch not taken", $time);
        end

    // Fibonacci LFSR with taps 32 22 2 1, new bit enters at the bottom
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [15:0] rand16();
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < 16; i++) begin
            stim_lfsr = lfsr_step(stim_lfsr);
            v         = {v[14:0], stim_lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [3:0] rand_reg();
        logic [15:0] r;
        r = rand16();
        return 4'(1 + int'(r) % 6);   // r1 to r6
    endfunction

    function automatic logic [XLEN-1:0] rand_addr();
        logic [15:0] r;
        r = rand16();
        return {22'h0, r[7:0], 2'b00};
    endfunction

    function automatic logic [XLEN-1:0] model_alu(input alu_op_t op, input logic [XLEN-1:0] a,
                                                  input logic [XLEN-1:0] b);
        case (op)
            ALU_MOV: return b;
            ALU_ADD: return a + b;
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            default: return '0;
        endcase
    endfunction

    task automatic finish_run();
        $display("Summary: %0d instructions, %0d value errors, %0d timeouts",
                 accepted, value_errors, timeouts);
        if (value_errors == 0 && timeouts == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout at %0t: %s did not happen within %0d cycles", $time, what, WAIT_LIMIT);
        timeouts++;
        finish_run();
    endtask

    task automatic wait_ready();
        int cycles;
        cycles = 0;
        while (!rdy_o) begin
            if (cycles == WAIT_LIMIT) begin
                report_timeout("return of rdy_o");
            end
            @(negedge clk);
            cycles++;
        end
    endtask

    task automatic wait_flush();
        int cycles;
        cycles = 0;
        while (!flush_o) begin
            if (cycles == WAIT_LIMIT) begin
                report_timeout("flush pulse");
            end
            @(negedge clk);
            cycles++;
        end
        @(negedge clk);             // Pulse is over here
        flush_allowed = 1'b0;
    endtask

    // Called on a falling edge, returns on the falling edge after the accept
    task automatic issue(input ctl_t c);
        wait_ready();
        ctl_i = c;
        req_i = 1'b1;
        @(negedge clk);
        req_i  = 1'b0;
        exp_pc = exp_pc + PC_STEP;
        accepted++;
    endtask

    task automatic run_alu(input alu_op_t op, input logic [3:0] rd, input logic [3:0] rm,
                           input logic [3:0] rn, input logic use_imm, input logic [15:0] imm,
                           input logic set_flags);
        ctl_t            c;
        logic [XLEN-1:0] result;
        c           = '0;
        c.op        = op;
        c.imm       = imm;
        c.rd        = rd;
        c.rm        = rm;
        c.rn        = rn;
        c.use_imm   = use_imm;
        c.dst       = DST_REG;
        c.set_flags = set_flags;
        result = model_alu(op, exp_regs[rm], use_imm ? {16'h0, imm} : exp_regs[rn]);
        if (rd == REG_PC) begin
            flush_allowed = 1'b1;   // r15 write is a jump
            exp_newpc     = result;
            issue(c);
            wait_flush();
            exp_pc = result;
        end else begin
            exp_regs[rd] = result;
            issue(c);
            wait_ready();
        end
    endtask

    task automatic store_word(input logic [3:0] rd, input logic [XLEN-1:0] addr);
        ctl_t c;
        c         = '0;
        c.op      = ALU_MOV;      // Address is the immediate
        c.use_imm = 1'b1;
        c.imm     = addr[15:0];
        c.rd      = rd;
        c.dst     = DST_STORE;
        exp_addr  = addr;
        exp_we    = 1'b1;
        exp_wdata = exp_regs[rd];
        issue(c);
        wait_ready();
    endtask

    task automatic load_word(input logic [3:0] rd, input logic [XLEN-1:0] addr,
                             input logic [XLEN-1:0] value);
        ctl_t c;
        c            = '0;
        c.op         = ALU_MOV;
        c.use_imm    = 1'b1;
        c.imm        = addr[15:0];
        c.rd         = rd;
        c.dst        = DST_LOAD;
        exp_addr     = addr;
        exp_we       = 1'b0;
        exp_regs[rd] = value;
        issue(c);
        wait_ready();
    endtask

    task automatic branch(input logic [3:0] cond, input logic taken);
        ctl_t        c;
        logic [15:0] imm;
        imm            = rand16();
        c              = '0;
        c.is_branch    = 1'b1;
        c.cond         = cond;
        c.imm          = imm;
        taken_expected = taken;
        if (taken) begin
            flush_allowed = 1'b1;
            exp_newpc     = exp_pc + {{16{imm[15]}}, imm};   // Relative to the branch itself
            issue(c);
            wait_flush();
            exp_pc = exp_newpc;
        end else begin
            issue(c);
        end
    endtask

    // Word memory that stalls and acknowledges at random
    initial begin : memory_model
        mem_ack_i   = 1'b0;
        mem_stall_i = 1'b0;
        mem_rdata_i = '0;
        mem_lfsr    = SEED;
        for (int i = 0; i < 256; i++) begin
            mem_words[i] = (32'(i) * 32'h9E37_79B9) ^ 32'h0F1E_2D3C;
        end
        forever begin
            @(negedge clk);
            mem_ack_i   = 1'b0;
            mem_stall_i = 1'b0;
            if (mem_phase == 0 && mem_stb_o) begin
                mem_phase = 1;
                stall_run = 0;
            end
            if (mem_phase == 1) begin
                mem_lfsr = lfsr_step(mem_lfsr);
                if (mem_lfsr[0] && stall_run < 3) begin
                    mem_stall_i = 1'b1;
                    stall_run++;
                end else begin
                    mem_lfsr  = lfsr_step(lfsr_step(mem_lfsr));
                    mem_delay = int'(mem_lfsr[1:0]);   // Zero to three cycles
                    mem_phase = 2;
                end
            end
            if (mem_phase == 2) begin
                if (mem_delay == 0) begin
                    if (mem_o.we) begin
                        mem_words[mem_o.addr[9:2]] = mem_o.wdata;
                    end
                    mem_rdata_i = mem_words[mem_o.addr[9:2]];
                    mem_ack_i   = 1'b1;
                    mem_phase   = 0;
                end else begin
                    mem_delay--;
                end
            end
        end
    end

    initial begin : stimulus
        alu_op_t         ops [5];
        logic [15:0]     a;
        logic [15:0]     b;
        logic [3:0]      src;
        logic [XLEN-1:0] addr_a;
        logic            eq;
        logic            lt;
        reset          = 1'b1;
        req_i          = 1'b0;
        ctl_i          = '0;
        stim_lfsr      = SEED;
        exp_pc         = '0;
        exp_addr       = '0;
        exp_wdata      = '0;
        exp_we         = 1'b0;
        exp_newpc      = '0;
        flush_allowed  = 1'b0;
        taken_expected = 1'b0;
        for (int i = 0; i < 15; i++) begin
            exp_regs[i] = '0;
        end
        ops = '{ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR};
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);

        for (int r = 1; r <= 6; r++) begin
            run_alu(ALU_MOV, 4'(r), 4'd0, 4'd0, 1'b1, rand16(), 1'b0);
        end
        for (int i = 0; i < 5; i++) begin
            run_alu(ops[i], 4'(7 + i), rand_reg(), rand_reg(), 1'b0, 16'h0, 1'b0);
            store_word(4'(7 + i), rand_addr());
        end

        // Round trip through memory via r12
        for (int k = 0; k < 8; k++) begin
            src    = 4'(7 + k % 5);
            addr_a = rand_addr();
            store_word(src, addr_a);
            load_word(4'd12, addr_a, exp_regs[src]);
            store_word(4'd12, rand_addr());
        end

        for (int k = 0; k < 4; k++) begin
            a = rand16();
            b = (k == 0) ? a : rand16();
            run_alu(ALU_MOV, 4'd1, 4'd0, 4'd0, 1'b1, a, 1'b0);
            run_alu(ALU_MOV, 4'd2, 4'd0, 4'd0, 1'b1, b, 1'b0);
            if (k == 3) begin
                run_alu(ALU_SUB, 4'd1, 4'd0, 4'd1, 1'b0, 16'h0, 1'b0);   // Negate r1
            end
            run_alu(ALU_SUB, 4'd3, 4'd1, 4'd2, 1'b0, 16'h0, 1'b1);
            eq = (exp_regs[1] == exp_regs[2]);
            lt = ($signed(exp_regs[1]) < $signed(exp_regs[2]));
            branch(COND_EQ, eq);
            branch(COND_NE, !eq);
            branch(COND_LT, lt);
            branch(COND_GE, !lt);
        end

        // Jumps through r15, each followed by a branch from the new PC
        run_alu(ALU_ADD, REG_PC, 4'd1, 4'd0, 1'b1, rand16() & 16'hFFFC, 1'b0);
        branch(COND_AL, 1'b1);
        run_alu(ALU_MOV, REG_PC, 4'd0, 4'd0, 1'b1, 16'h0400, 1'b0);
        branch(COND_AL_HI, 1'b1);
        run_alu(ALU_XOR, 4'd4, 4'd5, 4'd6, 1'b0, 16'h0, 1'b0);
        store_word(4'd4, rand_addr());

        repeat (2) @(negedge clk);
        finish_run();
    end

endmodule
